// ==== vision_steer_top.f ====
+incdir+source
source/tracker_pkg.sv
source/tracker_regs.sv
source/target_finder.sv
source/direction_classifier.sv
source/drive_fsm.sv
source/vision_steer_top.sv
test/tb_vision_steer.sv

// ==== run_sim.sh ====
#!/bin/sh
# build the testbench with Verilator and run it
# exit status is nonzero unless the pass line is printed

cd "$(dirname "$0")" || exit 1

verilator --binary -j 0 --top-module tb_vision_steer -f vision_steer_top.f \
  || { echo "build failed"; exit 1; }

out=$(./obj_dir/Vtb_vision_steer 2>&1)
echo "$out"

echo "$out" | grep -q "All tests passed!" && echo "simulation PASS" \
  || { echo "simulation FAIL"; exit 1; }

// ==== test/tb_vision_steer.sv ====
//------------------------------------------------
// testbench for the vision steering core
// drives each table row as one frame and checks
// the video path, frame decision and drive state
//------------------------------------------------
`include "tracker_config.svh"

module tb_vision_steer;

  import tracker_pkg::*;

  // one frame of stimulus with its expected results
  // org has one orange flag per third with left in bit 0
  typedef struct packed {
    logic         cfg_en;
    logic [1:0]   cfg_addr;
    logic [7:0]   cfg_data;
    logic [1:0]   ir_when;
    ir_cmd_e      ir_cmd;
    logic [11:0]  pix_l;
    logic [11:0]  pix_c;
    logic [11:0]  pix_r;
    logic [2:0]   org;
    logic [2:0]   lines;
    direction_e   dir;
    logic         det;
    drive_state_e drv;
  } frame_row_t;

  localparam int n_rows      = 8;
  localparam int gap_cycles  = 4;
  localparam int dec_timeout = 16;

  // when the remote command of a row is sent
  localparam logic [1:0] ir_none   = 2'd0;
  localparam logic [1:0] ir_before = 2'd1;
  localparam logic [1:0] ir_at_dec = 2'd2;

  // test colours in rgb444
  localparam logic [11:0] c_orange = 12'hC60;
  localparam logic [11:0] c_bright = 12'hF60;
  localparam logic [11:0] c_grey   = 12'h777;
  localparam logic [11:0] c_blue   = 12'h48C;

  logic         clk;
  logic         rst_n;
  logic [11:0]  raw_pix;
  logic         raw_active;
  logic         raw_frame_end;
  logic         cfg_we;
  logic [1:0]   cfg_addr;
  logic [7:0]   cfg_data;
  logic         ir_valid;
  ir_cmd_e      ir_cmd;
  video_t       vid_out;
  decision_t    dec;
  drive_state_e drive_state;
  logic         auto_mode;

  frame_row_t   rows [n_rows];
  // model copies of thresholds and drive outputs
  thresh_t      tb_thr;
  video_t       exp_vid;
  drive_state_e exp_drv;
  logic         exp_auto;

  vision_steer_top DUT (
    .clk           (clk),
    .rst_n         (rst_n),
    .raw_pix       (raw_pix),
    .raw_active    (raw_active),
    .raw_frame_end (raw_frame_end),
    .cfg_we        (cfg_we),
    .cfg_addr      (cfg_addr),
    .cfg_data      (cfg_data),
    .ir_valid      (ir_valid),
    .ir_cmd        (ir_cmd),
    .vid_out       (vid_out),
    .dec           (dec),
    .drive_state   (drive_state),
    .auto_mode     (auto_mode)
  );

  // 40 unit period
  always #20 clk = ~clk;

  task automatic fail_now(input string msg);
    $display("ERROR at time %0t: %s", $time, msg);
    $display("Test failures found");
    $fatal(1, "stopped at first mismatch");
  endtask

  task automatic timeout_fail(input int cycles);
    $display("Timed out: no frame decision within %0d cycles of the frame end", cycles);
    $display("Test failures found");
    $fatal(1, "stopped on timeout");
  endtask

  // each nibble x scales to 17 * x
  function automatic pixel_t expand(input logic [11:0] p);
    pixel_t e;
    e.r = 8'(p[11:8]) * 8'd17;
    e.g = 8'(p[7:4]) * 8'd17;
    e.b = 8'(p[3:0]) * 8'd17;
    return e;
  endfunction

  function automatic logic orange_rule(input pixel_t e, input thresh_t t);
    return (e.r >= t.red_min) && (e.g <= t.green_max)
        && (e.b <= t.blue_max) && (e.r > e.g);
  endfunction

  // expected vid_out one cycle after these inputs
  function automatic video_t model_pixel(input logic [11:0] p, input logic act,
                                         input logic fe);
    video_t v;
    pixel_t e;
    e           = expand(p);
    v.active    = act;
    v.frame_end = fe;
    if (!act) begin
      v.pix = '0;
    end else if (orange_rule(e, tb_thr)) begin
      v.pix = '{r: 8'h00, g: 8'hff, b: 8'h00};
    end else begin
      v.pix = e;
    end
    return v;
  endfunction

  // cmd_auto leaves the state alone
  function automatic drive_state_e cmd_state(input ir_cmd_e cmd, input drive_state_e cur);
    drive_state_e s;
    case (cmd)
      cmd_forward: s = drv_forward;
      cmd_left:    s = drv_left;
      cmd_right:   s = drv_right;
      cmd_reverse: s = drv_reverse;
      cmd_auto:    s = cur;
      default:     s = drv_stop;
    endcase
    return s;
  endfunction

  task automatic set_pixel(input logic [11:0] p, input logic act, input logic fe);
    raw_pix       = p;
    raw_active    = act;
    raw_frame_end = fe;
    exp_vid       = model_pixel(p, act, fe);
  endtask

  // sample outputs and drive inputs 2 units after the edge
  task automatic next_cycle();
    @(posedge clk);
    #2;
    assert (vid_out === exp_vid)
      else fail_now($sformatf("vid_out %h, expected %h", vid_out, exp_vid));
  endtask

  task automatic send_cmd(input ir_cmd_e cmd);
    ir_valid = 1'b1;
    ir_cmd   = cmd;
    exp_auto = (cmd == cmd_auto);
    exp_drv  = cmd_state(cmd, exp_drv);
  endtask

  task automatic check_state(input drive_state_e want, input string where);
    assert (drive_state === want)
      else fail_now($sformatf("%s: drive_state %s, expected %s", where,
                              drive_state.name(), want.name()));
    assert (auto_mode === exp_auto)
      else fail_now($sformatf("%s: auto_mode %b, expected %b", where, auto_mode, exp_auto));
  endtask

  task automatic run_frame(input frame_row_t row);
    logic [11:0] p;
    int          n;
    int          ln;
    int          col;
    logic        got;
    if (row.cfg_en) begin
      cfg_we   = 1'b1;
      cfg_addr = row.cfg_addr;
      cfg_data = row.cfg_data;
      case (row.cfg_addr)
        2'd0:    tb_thr.red_min   = row.cfg_data;
        2'd1:    tb_thr.green_max = row.cfg_data;
        2'd2:    tb_thr.blue_max  = row.cfg_data;
        default: tb_thr.min_cnt   = row.cfg_data;
      endcase
      set_pixel(12'($urandom), 1'b0, 1'b0);
      next_cycle();
      cfg_we = 1'b0;
    end
    // table colours must agree with the rule under current thresholds
    assert (orange_rule(expand(row.pix_l), tb_thr) == row.org[0])
      else fail_now("left colour does not match its orange flag");
    assert (orange_rule(expand(row.pix_c), tb_thr) == row.org[1])
      else fail_now("centre colour does not match its orange flag");
    assert (orange_rule(expand(row.pix_r), tb_thr) == row.org[2])
      else fail_now("right colour does not match its orange flag");
    if (row.ir_when == ir_before) begin
      send_cmd(row.ir_cmd);
      set_pixel(12'($urandom), 1'b0, 1'b0);
      next_cycle();
      ir_valid = 1'b0;
      check_state(exp_drv, "one cycle after command");
    end
    for (ln = 0; ln < int'(row.lines); ln++) begin
      for (col = 0; col < `TRK_H_ACTIVE; col++) begin
        if (col < `TRK_THIRD) begin
          p = row.pix_l;
        end else if (col < 2 * `TRK_THIRD) begin
          p = row.pix_c;
        end else begin
          p = row.pix_r;
        end
        set_pixel(p, 1'b1, 1'b0);
        next_cycle();
      end
      // blanking noise must come out black
      repeat (gap_cycles) begin
        set_pixel(12'($urandom), 1'b0, 1'b0);
        next_cycle();
      end
    end
    set_pixel(12'($urandom), 1'b0, 1'b1);
    n   = 0;
    got = 1'b0;
    while (!got && (n < dec_timeout)) begin
      next_cycle();
      n++;
      if (dec.valid) begin
        got = 1'b1;
      end else begin
        set_pixel(12'($urandom), 1'b0, 1'b0);
      end
    end
    if (!got) begin
      timeout_fail(dec_timeout);
    end
    assert (n == 2)
      else fail_now($sformatf("dec.valid %0d cycles after frame end, expected 2", n));
    assert (dec.dir === row.dir)
      else fail_now($sformatf("dec.dir %s, expected %s", dec.dir.name(), row.dir.name()));
    assert (dec.detected === row.det)
      else fail_now($sformatf("dec.detected %b, expected %b", dec.detected, row.det));
    // command in the same cycle as the decision
    if (row.ir_when == ir_at_dec) begin
      send_cmd(row.ir_cmd);
    end
    set_pixel(12'($urandom), 1'b0, 1'b0);
    next_cycle();
    ir_valid = 1'b0;
    exp_drv  = row.drv;
    check_state(row.drv, "after frame decision");
  endtask

  task automatic load_table();
    rows[0] = '{1'b0, 2'd0, 8'd0, ir_before, cmd_forward, c_orange, c_grey, c_grey,
                3'b001, 3'd4, dir_left, 1'b1, drv_forward};
    rows[1] = '{1'b0, 2'd0, 8'd0, ir_before, cmd_auto, c_grey, c_grey, c_orange,
                3'b100, 3'd4, dir_right, 1'b1, drv_right};
    rows[2] = '{1'b0, 2'd0, 8'd0, ir_none, cmd_stop, c_orange, c_orange, c_orange,
                3'b111, 3'd4, dir_center, 1'b1, drv_forward};
    // 24 orange pixels is below the reset minimum of 32
    rows[3] = '{1'b0, 2'd0, 8'd0, ir_none, cmd_stop, c_orange, c_grey, c_grey,
                3'b001, 3'd3, dir_none, 1'b0, drv_stop};
    rows[4] = '{1'b1, 2'd3, 8'd4, ir_none, cmd_stop, c_orange, c_grey, c_grey,
                3'b001, 3'd3, dir_left, 1'b1, drv_left};
    rows[5] = '{1'b1, 2'd0, 8'd220, ir_none, cmd_stop, c_orange, c_orange, c_orange,
                3'b000, 3'd4, dir_none, 1'b0, drv_stop};
    rows[6] = '{1'b0, 2'd0, 8'd0, ir_at_dec, cmd_reverse, c_grey, c_grey, c_bright,
                3'b100, 3'd4, dir_right, 1'b1, drv_reverse};
    rows[7] = '{1'b0, 2'd0, 8'd0, ir_before, cmd_left, c_blue, c_grey, c_blue,
                3'b000, 3'd4, dir_none, 1'b0, drv_left};
  endtask

  initial begin
    void'($urandom(19));
    clk           = 1'b0;
    rst_n         = 1'b0;
    raw_pix       = '0;
    raw_active    = 1'b0;
    raw_frame_end = 1'b0;
    cfg_we        = 1'b0;
    cfg_addr      = '0;
    cfg_data      = '0;
    ir_valid      = 1'b0;
    ir_cmd        = cmd_stop;
    tb_thr        = '{red_min: `TRK_RED_MIN_RST, green_max: `TRK_GREEN_MAX_RST,
                      blue_max: `TRK_BLUE_MAX_RST, min_cnt: `TRK_MIN_CNT_RST};
    exp_vid       = '0;
    exp_drv       = drv_stop;
    exp_auto      = 1'b0;
    load_table();
    repeat (8) @(posedge clk);
    #2;
    rst_n = 1'b1;
    // defaults straight out of reset
    assert (vid_out === '0)
      else fail_now($sformatf("vid_out %h after reset, expected 0", vid_out));
    assert (dec === '0)
      else fail_now($sformatf("dec %h after reset, expected 0", dec));
    assert (DUT.u_regs.thr === tb_thr)
      else fail_now($sformatf("thresholds %h after reset, expected %h",
                              DUT.u_regs.thr, tb_thr));
    check_state(drv_stop, "after reset");
    for (int i = 0; i < n_rows; i++) begin
      run_frame(rows[i]);
    end
    $display("All tests passed!");
    $finish;
  end

endmodule

// ==== source/vision_steer_top.sv ====
//------------------------------------------------
// pixel processing and steering core, top level
// pixel stream and remote commands in, marked
// video, decision and drive state out
//------------------------------------------------
module vision_steer_top (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic [11:0]               raw_pix,
  input  logic                      raw_active,
  input  logic                      raw_frame_end,
  input  logic                      cfg_we,
  input  logic [1:0]                cfg_addr,
  input  logic [7:0]                cfg_data,
  input  logic                      ir_valid,
  input  tracker_pkg::ir_cmd_e      ir_cmd,
  output tracker_pkg::video_t       vid_out,
  output tracker_pkg::decision_t    dec,
  output tracker_pkg::drive_state_e drive_state,
  output logic                      auto_mode
);

  import tracker_pkg::*;

  // thresholds shared by both vision blocks
  thresh_t thr;
  logic    is_orange;

  tracker_regs u_regs (
    .clk      (clk),
    .rst_n    (rst_n),
    .cfg_we   (cfg_we),
    .cfg_addr (cfg_addr),
    .cfg_data (cfg_data),
    .thr      (thr)
  );

  // marker overlay, flag aligned with vid_out
  target_finder u_finder (
    .clk           (clk),
    .rst_n         (rst_n),
    .raw_pix       (raw_pix),
    .raw_active    (raw_active),
    .raw_frame_end (raw_frame_end),
    .thr           (thr),
    .vid_out       (vid_out),
    .is_orange     (is_orange)
  );

  direction_classifier u_classifier (
    .clk       (clk),
    .rst_n     (rst_n),
    .vid_in    (vid_out),
    .is_orange (is_orange),
    .thr       (thr),
    .dec       (dec)
  );

  drive_fsm u_drive (
    .clk         (clk),
    .rst_n       (rst_n),
    .ir_valid    (ir_valid),
    .ir_cmd      (ir_cmd),
    .dec         (dec),
    .drive_state (drive_state),
    .auto_mode   (auto_mode)
  );

endmodule

// ==== source/drive_fsm.sv ====
//------------------------------------------------
// drive state machine of the rover
// remote commands set manual moves or auto mode
// in auto mode camera decisions steer the state
//------------------------------------------------
module drive_fsm (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      ir_valid,
  input  tracker_pkg::ir_cmd_e      ir_cmd,
  input  tracker_pkg::decision_t    dec,
  output tracker_pkg::drive_state_e drive_state,
  output logic                      auto_mode
);

  import tracker_pkg::*;

  drive_state_e state_d;
  logic         auto_d;

  always_comb begin
    state_d = drive_state;
    auto_d  = auto_mode;
    // remote has priority over the camera
    if (ir_valid) begin
      case (ir_cmd)
        cmd_stop: begin
          auto_d  = 1'b0;
          state_d = drv_stop;
        end
        cmd_forward: begin
          auto_d  = 1'b0;
          state_d = drv_forward;
        end
        cmd_left: begin
          auto_d  = 1'b0;
          state_d = drv_left;
        end
        cmd_right: begin
          auto_d  = 1'b0;
          state_d = drv_right;
        end
        cmd_reverse: begin
          auto_d  = 1'b0;
          state_d = drv_reverse;
        end
        cmd_auto: begin
          // keep moving as before until a decision arrives
          auto_d = 1'b1;
        end
        default: begin
        end
      endcase
    end else if (auto_mode && dec.valid) begin
      case (dec.dir)
        dir_left:   state_d = drv_left;
        dir_right:  state_d = drv_right;
        dir_center: state_d = drv_forward;
        // target lost
        default:    state_d = drv_stop;
      endcase
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      drive_state <= drv_stop;
      auto_mode   <= 1'b0;
    end else begin
      drive_state <= state_d;
      auto_mode   <= auto_d;
    end
  end

  // motor driver decodes only the five defined states
  a_state_legal: assert property (
    @(posedge clk) disable iff (!rst_n)
    drive_state inside {drv_stop, drv_forward, drv_left, drv_right, drv_reverse}
  );

endmodule

// ==== source/direction_classifier.sv ====
//------------------------------------------------
// counts orange pixels per third of the line over
// a frame, decides steering direction at frame end
// dec.valid pulses one cycle after vid_in.frame_end
//------------------------------------------------
`include "tracker_config.svh"

module direction_classifier (
  input  logic                   clk,
  input  logic                   rst_n,
  input  tracker_pkg::video_t    vid_in,
  input  logic                   is_orange,
  input  tracker_pkg::thresh_t   thr,
  output tracker_pkg::decision_t dec
);

  import tracker_pkg::*;

  localparam int col_w = $clog2(`TRK_H_ACTIVE + 1);
  // sum of three counters needs two extra bits
  localparam int tot_w = `TRK_CNT_W + 2;

  logic [col_w-1:0]      col;
  logic [`TRK_CNT_W-1:0] cnt_left;
  logic [`TRK_CNT_W-1:0] cnt_center;
  logic [`TRK_CNT_W-1:0] cnt_right;
  logic [tot_w-1:0]      cnt_total;
  logic [tot_w-1:0]      cnt_min;
  direction_e            third;
  direction_e            dir_pick;
  logic                  hit;
  logic                  found;

  // counter that sticks at all ones
  function automatic logic [`TRK_CNT_W-1:0] sat_inc(
    input logic [`TRK_CNT_W-1:0] cnt,
    input logic                  en
  );
    return (en && (cnt != '1)) ? cnt + 1'b1 : cnt;
  endfunction

  assign hit = vid_in.active && is_orange;

  // which third the current column falls in
  always_comb begin
    if (col < `TRK_THIRD) begin
      third = dir_left;
    end else if (col < (2 * `TRK_THIRD)) begin
      third = dir_center;
    end else begin
      third = dir_right;
    end
  end

  // column position, restarts every line
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      col <= '0;
    end else if (vid_in.active) begin
      col <= col + 1'b1;
    end else begin
      col <= '0;
    end
  end

  // frame counters, cleared when the decision is taken
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cnt_left   <= '0;
      cnt_center <= '0;
      cnt_right  <= '0;
    end else if (vid_in.frame_end) begin
      cnt_left   <= '0;
      cnt_center <= '0;
      cnt_right  <= '0;
    end else begin
      cnt_left   <= sat_inc(cnt_left, hit && (third == dir_left));
      cnt_center <= sat_inc(cnt_center, hit && (third == dir_center));
      cnt_right  <= sat_inc(cnt_right, hit && (third == dir_right));
    end
  end

  assign cnt_total = tot_w'(cnt_left) + tot_w'(cnt_center) + tot_w'(cnt_right);
  assign cnt_min   = tot_w'(thr.min_cnt) << `TRK_MIN_CNT_SHIFT;
  assign found     = (cnt_total >= cnt_min);

  // largest third wins
  // ties go centre, then left, then right
  always_comb begin
    if ((cnt_center >= cnt_left) && (cnt_center >= cnt_right)) begin
      dir_pick = dir_center;
    end else if (cnt_left >= cnt_right) begin
      dir_pick = dir_left;
    end else begin
      dir_pick = dir_right;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      dec <= '{valid: 1'b0, dir: dir_none, detected: 1'b0};
    end else begin
      dec.valid <= vid_in.frame_end;
      if (vid_in.frame_end) begin
        dec.detected <= found;
        dec.dir      <= found ? dir_pick : dir_none;
      end
    end
  end

  // one decision per frame end pulse
  a_dec_single_pulse: assert property (
    @(posedge clk) disable iff (!rst_n)
    dec.valid |=> !dec.valid
  );

  // lines longer than the build geometry would land in the wrong third
  a_col_in_line: assert property (
    @(posedge clk) disable iff (!rst_n)
    vid_in.active |-> (col < `TRK_H_ACTIVE)
  );

endmodule

// ==== source/target_finder.sv ====
//------------------------------------------------
// pixel stage of the tracker
// expands rgb444, flags orange pixels and paints
// them green, one register of latency
//------------------------------------------------
module target_finder (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic [11:0]          raw_pix,
  input  logic                 raw_active,
  input  logic                 raw_frame_end,
  input  tracker_pkg::thresh_t thr,
  output tracker_pkg::video_t  vid_out,
  output logic                 is_orange
);

  import tracker_pkg::*;

  // marker colour on the video output
  localparam pixel_t marker_pix = '{r: 8'h00, g: 8'hff, b: 8'h00};

  pixel_t exp_pix;
  pixel_t mark_pix;
  logic   orange_hit;

  // registered outputs
  pixel_t pix_q;
  logic   active_q;
  logic   frame_end_q;
  logic   orange_q;

  // nibble replication, x becomes 17 * x
  assign exp_pix = '{
    r: {raw_pix[11:8], raw_pix[11:8]},
    g: {raw_pix[7:4], raw_pix[7:4]},
    b: {raw_pix[3:0], raw_pix[3:0]}
  };

  // orange rule
  // red strong and above green, green and blue capped
  assign orange_hit = raw_active
                   && (exp_pix.r >= thr.red_min)
                   && (exp_pix.g <= thr.green_max)
                   && (exp_pix.b <= thr.blue_max)
                   && (exp_pix.r > exp_pix.g);

  always_comb begin
    if (!raw_active) begin
      // blanking goes out black
      mark_pix = '0;
    end else if (orange_hit) begin
      mark_pix = marker_pix;
    end else begin
      mark_pix = exp_pix;
    end
  end

  // timing and flag
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      active_q    <= 1'b0;
      frame_end_q <= 1'b0;
      orange_q    <= 1'b0;
    end else begin
      active_q    <= raw_active;
      frame_end_q <= raw_frame_end;
      orange_q    <= orange_hit;
    end
  end

  // pixel payload
  always_ff @(posedge clk) begin
    pix_q <= mark_pix;
  end

  assign vid_out   = '{pix: pix_q, active: active_q, frame_end: frame_end_q};
  assign is_orange = orange_q;

  // classifier relies on the flag never firing in blanking
  a_orange_in_active: assert property (
    @(posedge clk) disable iff (!rst_n)
    is_orange |-> vid_out.active
  );

endmodule

// ==== source/tracker_regs.sv ====
//------------------------------------------------
// threshold registers for the orange detector
// written one byte at a time through cfg_we
//------------------------------------------------
`include "tracker_config.svh"

module tracker_regs (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                cfg_we,
  input  logic [1:0]          cfg_addr,
  input  logic [7:0]          cfg_data,
  output tracker_pkg::thresh_t thr
);

  // register map
  localparam logic [1:0] addr_red_min   = 2'd0;
  localparam logic [1:0] addr_green_max = 2'd1;
  localparam logic [1:0] addr_blue_max  = 2'd2;
  localparam logic [1:0] addr_min_cnt   = 2'd3;

  // write lands on the strobe edge
  // so the new value is seen next cycle
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      thr.red_min   <= `TRK_RED_MIN_RST;
      thr.green_max <= `TRK_GREEN_MAX_RST;
      thr.blue_max  <= `TRK_BLUE_MAX_RST;
      thr.min_cnt   <= `TRK_MIN_CNT_RST;
    end else if (cfg_we) begin
      case (cfg_addr)
        addr_red_min: begin
          thr.red_min <= cfg_data;
        end
        addr_green_max: begin
          thr.green_max <= cfg_data;
        end
        addr_blue_max: begin
          thr.blue_max <= cfg_data;
        end
        addr_min_cnt: begin
          // scaled by the classifier
          thr.min_cnt <= cfg_data;
        end
        default: begin
        end
      endcase
    end
  end

  // a write to an unknown address would corrupt a threshold silently
  a_cfg_addr_known: assert property (
    @(posedge clk) disable iff (!rst_n)
    cfg_we |-> !$isunknown(cfg_addr)
  );

endmodule

// ==== source/tracker_pkg.sv ====
//------------------------------------------------
// shared types for the orange tracker core
// video, threshold and decision structs plus the
// direction, command and drive state enums
//------------------------------------------------
package tracker_pkg;

  // expanded pixel, 8 bits per channel
  typedef struct packed {
    logic [7:0] r;
    logic [7:0] g;
    logic [7:0] b;
  } pixel_t;

  // pixel plus its timing bits
  typedef struct packed {
    pixel_t pix;
    logic   active;
    logic   frame_end;
  } video_t;

  // programmable orange rule
  typedef struct packed {
    logic [7:0] red_min;
    logic [7:0] green_max;
    logic [7:0] blue_max;
    logic [7:0] min_cnt;
  } thresh_t;

  typedef enum logic [1:0] {
    dir_none,
    dir_left,
    dir_center,
    dir_right
  } direction_e;

  // valid pulses once per frame
  typedef struct packed {
    logic       valid;
    direction_e dir;
    logic       detected;
  } decision_t;

  // decoded remote buttons
  typedef enum logic [2:0] {
    cmd_stop,
    cmd_forward,
    cmd_left,
    cmd_right,
    cmd_auto,
    cmd_reverse
  } ir_cmd_e;

  typedef enum logic [2:0] {
    drv_stop,
    drv_forward,
    drv_left,
    drv_right,
    drv_reverse
  } drive_state_e;

endpackage

// ==== source/tracker_config.svh ====
//------------------------------------------------
// build constants for the orange tracker core
// include where frame geometry, reset thresholds
// or counter widths are needed
//------------------------------------------------
`ifndef TRACKER_CONFIG_SVH
`define TRACKER_CONFIG_SVH

// active pixels in one line
`define TRK_H_ACTIVE 24
// pixels in each third of a line
`define TRK_THIRD 8

// per-third frame counter width
`define TRK_CNT_W 16

// reset thresholds in 8-bit channel units
`define TRK_RED_MIN_RST 8'd160
`define TRK_GREEN_MAX_RST 8'd144
`define TRK_BLUE_MAX_RST 8'd96

// minimum orange count, register units
`define TRK_MIN_CNT_RST 8'd8
// register value is scaled up by this shift
`define TRK_MIN_CNT_SHIFT 2

`endif
